// File: cpu_lite.f
+incdir+hdl
hdl/isa_pkg.sv
hdl/host_pkg.sv
hdl/instr_store.sv
hdl/exec_core.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/cpu_lite_top.sv
test/cpu_lite_asserts.sv
test/cpu_lite_tb.sv

// File: test/cpu_lite_tb.sv
`default_nettype none

`include "cpu_lite_defs.svh"

module cpu_lite_tb
    import isa_pkg::*;
    import host_pkg::*;
();

    localparam int CLK_PERIOD  = 100;
    localparam int DONE_LIMIT  = 4 * `IMEM_DEPTH;
    localparam int SWEEP_LIMIT = 8 * `REG_COUNT + 20;
    localparam instr_t LATE_WORD = {12'd1, 5'd5, 3'b000, 5'd5, 7'b0010011};  // adds 1 to x5

    logic      clk;
    logic      reset;
    logic      host_valid;
    byte_t     host_byte;
    reg_addr_t reg_sel;
    byte_sel_t byte_sel;
    byte_t     value;
    logic      is_positive;
    logic      done;

    word_t     model_regs [`REG_COUNT];  // expected register contents
    instr_t    prog_q [$];               // words sent to the loader
    logic      compare_req;              // main -> compare process

    cpu_lite_top u_dut (
        .clk_i         (clk),
        .reset         (reset),
        .host_valid_i  (host_valid),
        .host_byte_i   (host_byte),
        .reg_sel_i     (reg_sel),
        .byte_sel_i    (byte_sel),
        .value_o       (value),
        .is_positive_o (is_positive),
        .done_o        (done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_on_failure();
        $display("Test failed");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
        if (actual !== expected) begin
            $display("** Error at time %0t: %s expected 0x%h, got 0x%h",
                     $time, name, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("** Error at time %0t: %s expected %b, got %b",
                     $time, name, expected, actual);
            stop_on_failure();
        end
    endtask

    // expected effect of one executed word on model_regs
    function automatic void step_model(input instr_t instr);
        word_t      a;
        word_t      b;
        word_t      imm;
        word_t      res;
        logic       writes;
        logic [2:0] f3;
        logic [6:0] f7;
        a      = model_regs[instr[19:15]];
        b      = model_regs[instr[24:20]];
        imm    = {{20{instr[31]}}, instr[31:20]};
        f3     = instr[14:12];
        f7     = instr[31:25];
        res    = '0;
        writes = 1'b1;
        if (instr[6:0] == 7'b0110011) begin
            case ({f7, f3})
                {7'h00, 3'b000}: res = a + b;
                {7'h20, 3'b000}: res = a - b;
                {7'h00, 3'b111}: res = a & b;
                {7'h00, 3'b110}: res = a | b;
                {7'h00, 3'b100}: res = a ^ b;
                {7'h00, 3'b001}: res = a << b[4:0];
                {7'h00, 3'b010}: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                default:         writes = 1'b0;
            endcase
        end else if (instr[6:0] == 7'b0010011) begin
            case (f3)
                3'b000:  res = a + imm;
                3'b111:  res = a & imm;
                3'b110:  res = a | imm;
                default: writes = 1'b0;
            endcase
        end else begin
            writes = 1'b0;  // unknown opcode
        end
        if (writes && (instr[11:7] != 5'd0)) begin
            model_regs[instr[11:7]] = res;
        end
    endfunction

    function automatic logic [4:0] pick_reg();
        // mostly low registers so results feed later instructions
        if ($urandom_range(0, 3) == 0) begin
            return 5'($urandom);
        end
        return 5'($urandom_range(0, 7));
    endfunction

    function automatic instr_t random_instr();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        rd  = pick_reg();
        rs1 = pick_reg();
        rs2 = pick_reg();
        imm = 12'($urandom);  // negative half the time
        case ($urandom_range(0, 11))
            0:  return {7'h00, rs2, rs1, 3'b000, rd, 7'b0110011};
            1:  return {7'h20, rs2, rs1, 3'b000, rd, 7'b0110011};
            2:  return {7'h00, rs2, rs1, 3'b111, rd, 7'b0110011};
            3:  return {7'h00, rs2, rs1, 3'b110, rd, 7'b0110011};
            4:  return {7'h00, rs2, rs1, 3'b100, rd, 7'b0110011};
            5:  return {7'h00, rs2, rs1, 3'b001, rd, 7'b0110011};
            6:  return {7'h00, rs2, rs1, 3'b010, rd, 7'b0110011};
            7:  return {imm, rs1, 3'b000, rd, 7'b0010011};
            8:  return {imm, rs1, 3'b111, rd, 7'b0010011};
            9:  return {imm, rs1, 3'b110, rd, 7'b0010011};
            10: return {imm, rs1, 3'b001, rd, 7'b0010011};  // slli is unsupported
            default: return {imm, rs1, 3'b010, rd, 7'b0000011};  // load opcode
        endcase
    endfunction

    task automatic build_program(input int n_words);
        prog_q.delete();
        repeat (n_words) prog_q.push_back(random_instr());
    endtask

    task automatic clear_model();
        for (int r = 0; r < `REG_COUNT; r++) begin
            model_regs[r] = '0;
        end
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        repeat (5) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic send_byte(input byte_t b);
        @(negedge clk);
        host_valid = 1'b1;
        host_byte  = b;
    endtask

    task automatic idle_byte();
        @(negedge clk);
        host_valid = 1'b0;
        host_byte  = byte_t'($urandom);  // random value the loader ignores
    endtask

    task automatic wait_done(input int max_cycles, output int cycles);
        cycles = 0;
        while (done !== 1'b1) begin
            if (cycles >= max_cycles) begin
                $display("Timeout: done_o stayed low for %0d cycles", max_cycles);
                stop_on_failure();
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
    endtask

    task automatic compare_all();
        int n;
        n           = 0;
        compare_req = 1'b1;
        while (compare_req) begin
            if (n >= SWEEP_LIMIT) begin
                $display("Timeout: the register sweep did not finish");
                stop_on_failure();
            end else begin
                @(negedge clk);
                n++;
            end
        end
    endtask

    task automatic run_and_compare();
        int cycles;
        int n_exec;
        int expected_lat;
        n_exec       = (prog_q.size() > `IMEM_DEPTH) ? `IMEM_DEPTH : prog_q.size();
        expected_lat = (n_exec == 0) ? 1 : n_exec;
        for (int i = 0; i < n_exec; i++) begin
            step_model(prog_q[i]);
        end
        repeat (3) send_byte(byte_t'($urandom_range(0, 8'hFD)));  // before start
        send_byte(`START_MARKER);
        foreach (prog_q[i]) begin
            for (int k = 0; k < 4; k++) begin
                send_byte(prog_q[i][8*k +: 8]);  // lsb first
                idle_byte();
            end
        end
        send_byte(`END_MARKER);
        idle_byte();
        wait_done(DONE_LIMIT, cycles);
        if (cycles != expected_lat) begin
            $display("done_o rose %0d cycles after run instead of %0d", cycles, expected_lat);
            stop_on_failure();
        end
        send_byte(`START_MARKER);  // after the end marker
        for (int k = 0; k < 4; k++) begin
            send_byte(LATE_WORD[8*k +: 8]);
        end
        send_byte(`END_MARKER);
        idle_byte();
        compare_all();
    endtask

    task automatic sweep_registers();
        word_t expected;
        for (int r = 0; r < `REG_COUNT; r++) begin
            expected = model_regs[r];
            for (int l = 0; l < 4; l++) begin
                @(negedge clk);
                reg_sel  = reg_addr_t'(r);
                byte_sel = byte_sel_t'(l);
                @(posedge clk);  // no writes once done
                check_byte($sformatf("value_o (x%0d lane %0d)", r, l),
                           expected[8*l +: 8], value);
                check_flag($sformatf("is_positive_o (x%0d)", r),
                           ~expected[`XLEN-1], is_positive);
            end
        end
    endtask

    // compare process
    initial begin
        forever begin
            @(posedge clk);
            if (compare_req) begin
                sweep_registers();
                compare_req = 1'b0;
            end
        end
    end

    initial begin
        void'($urandom(86430));
        reset       = 1'b1;
        host_valid  = 1'b0;
        host_byte   = '0;
        reg_sel     = '0;
        byte_sel    = '0;
        compare_req = 1'b0;
        clear_model();
        apply_reset();
        check_flag("done_o", 1'b0, done);
        compare_all();  // all zero after reset

        for (int round = 0; round < 3; round++) begin
            apply_reset();
            clear_model();
            build_program($urandom_range(1, `IMEM_DEPTH));
            run_and_compare();
        end

        apply_reset();  // overflow drops the extra words
        clear_model();
        build_program(`IMEM_DEPTH + 4);
        run_and_compare();

        apply_reset();  // empty program
        clear_model();
        prog_q.delete();
        run_and_compare();

        if (u_dut.u_asserts.assert_errors == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("%0d assertion failures were reported", u_dut.u_asserts.assert_errors);
            stop_on_failure();
        end
    end

endmodule

`default_nettype wire

// File: test/cpu_lite_asserts.sv
`default_nettype none

module cpu_lite_asserts
    import isa_pkg::*;
    import host_pkg::*;
(
    input  logic      clk_i,
    input  logic      reset,
    input  logic      done_i,
    input  logic      run_i,
    input  logic      wr_en_i,
    input  reg_addr_t wr_addr_i,
    input  reg_addr_t reg_sel_i,
    input  byte_t     value_i
);

    int unsigned assert_errors = 0;  // read by the testbench at the end

    done_sticky: assert property (@(posedge clk_i) disable iff (reset) done_i |=> done_i)
        else begin
            $error("done_o fell while reset was low");
            assert_errors = assert_errors + 1;
        end

    done_needs_run: assert property (@(posedge clk_i) disable iff (reset) done_i |-> run_i)
        else begin
            $error("done_o high while the loader is not in RUN");
            assert_errors = assert_errors + 1;
        end

    no_x0_write: assert property (@(posedge clk_i) disable iff (reset)
                                  wr_en_i |-> (wr_addr_i != '0))
        else begin
            $error("register write aimed at x0");
            assert_errors = assert_errors + 1;
        end

    x0_reads_zero: assert property (@(posedge clk_i) disable iff (reset)
                                    (reg_sel_i == '0) |-> (value_i == '0))
        else begin
            $error("host readout of x0 is nonzero");
            assert_errors = assert_errors + 1;
        end

endmodule

bind cpu_lite_top cpu_lite_asserts u_asserts (
    .clk_i     (clk_i),
    .reset     (reset),
    .done_i    (done_o),
    .run_i     (run),
    .wr_en_i   (wr_en),
    .wr_addr_i (wr_addr),
    .reg_sel_i (reg_sel_i),
    .value_i   (value_o)
);

`default_nettype wire

// File: hdl/cpu_lite_top.sv
`default_nettype none

`include "cpu_lite_defs.svh"

module cpu_lite_top
    import isa_pkg::*;
    import host_pkg::*;
(
    input  logic      clk_i,
    input  logic      reset,
    input  logic      host_valid_i,
    input  byte_t     host_byte_i,
    input  reg_addr_t reg_sel_i,
    input  byte_sel_t byte_sel_i,
    output byte_t     value_o,
    output logic      is_positive_o,
    output logic      done_o
);

    logic                  run;
    logic [`IMEM_ADDR_W:0] instr_count;
    imem_addr_t            fetch_addr;
    instr_t                fetch_instr;
    reg_addr_t             rs1_addr;
    reg_addr_t             rs2_addr;
    word_t                 rs1_data;
    word_t                 rs2_data;
    word_t                 operand_a;
    word_t                 operand_b;
    alu_op_t               alu_op;
    word_t                 alu_result;
    logic                  wr_en;
    reg_addr_t             wr_addr;
    word_t                 wr_data;

    instr_store u_instr_store (
        .clk_i         (clk_i),
        .reset         (reset),
        .host_valid_i  (host_valid_i),
        .host_byte_i   (host_byte_i),
        .fetch_addr_i  (fetch_addr),
        .fetch_instr_o (fetch_instr),
        .instr_count_o (instr_count),
        .run_o         (run)
    );

    exec_core u_exec_core (
        .clk_i         (clk_i),
        .reset         (reset),
        .run_i         (run),
        .instr_count_i (instr_count),
        .instr_i       (fetch_instr),
        .fetch_addr_o  (fetch_addr),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .operand_a_o   (operand_a),
        .operand_b_o   (operand_b),
        .alu_op_o      (alu_op),
        .result_i      (alu_result),
        .wr_en_o       (wr_en),
        .wr_addr_o     (wr_addr),
        .wr_data_o     (wr_data),
        .done_o        (done_o)
    );

    alu u_alu (
        .operand_a_i (operand_a),
        .operand_b_i (operand_b),
        .alu_op_i    (alu_op),
        .result_o    (alu_result)
    );

    reg_file u_reg_file (
        .clk_i         (clk_i),
        .reset         (reset),
        .rs1_addr_i    (rs1_addr),
        .rs2_addr_i    (rs2_addr),
        .rs1_data_o    (rs1_data),
        .rs2_data_o    (rs2_data),
        .wr_en_i       (wr_en),
        .wr_addr_i     (wr_addr),
        .wr_data_i     (wr_data),
        .reg_sel_i     (reg_sel_i),
        .byte_sel_i    (byte_sel_i),
        .value_o       (value_o),
        .is_positive_o (is_positive_o)
    );

endmodule

`default_nettype wire

// File: hdl/reg_file.sv
`default_nettype none

`include "cpu_lite_defs.svh"

module reg_file
    import isa_pkg::*;
    import host_pkg::*;
(
    input  logic      clk_i,
    input  logic      reset,
    input  reg_addr_t rs1_addr_i,
    input  reg_addr_t rs2_addr_i,
    output word_t     rs1_data_o,
    output word_t     rs2_data_o,
    input  logic      wr_en_i,
    input  reg_addr_t wr_addr_i,
    input  word_t     wr_data_i,
    input  reg_addr_t reg_sel_i,
    input  byte_sel_t byte_sel_i,
    output byte_t     value_o,
    output logic      is_positive_o
);

    word_t regs [`REG_COUNT];
    word_t sel_word;  // register picked by host

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && (wr_addr_i != '0)) begin
            regs[wr_addr_i] <= wr_data_i;  // x0 stays zero
        end
    end

    assign rs1_data_o = regs[rs1_addr_i];
    assign rs2_data_o = regs[rs2_addr_i];

    // host readout
    assign sel_word      = regs[reg_sel_i];
    assign value_o       = sel_word[{byte_sel_i, 3'b000} +: 8];
    assign is_positive_o = ~sel_word[`XLEN-1];

endmodule

`default_nettype wire

// File: hdl/alu.sv
`default_nettype none

module alu
    import isa_pkg::*;
(
    input  word_t   operand_a_i,
    input  word_t   operand_b_i,
    input  alu_op_t alu_op_i,
    output word_t   result_o
);

    always_comb begin
        case (alu_op_i)
            ALU_ADD: result_o = operand_a_i + operand_b_i;
            ALU_SUB: result_o = operand_a_i - operand_b_i;
            ALU_AND: result_o = operand_a_i & operand_b_i;
            ALU_OR:  result_o = operand_a_i | operand_b_i;
            ALU_XOR: result_o = operand_a_i ^ operand_b_i;
            ALU_SLL: result_o = operand_a_i << operand_b_i[4:0];  // low five bits only
            ALU_SLT: begin
                // signed compare, result is 0 or 1
                if ($signed(operand_a_i) < $signed(operand_b_i)) begin
                    result_o = word_t'(1);
                end else begin
                    result_o = '0;
                end
            end
            default: result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/exec_core.sv
`default_nettype none

`include "cpu_lite_defs.svh"

module exec_core
    import isa_pkg::*;
    import host_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  reset,
    input  logic                  run_i,
    input  logic [`IMEM_ADDR_W:0] instr_count_i,
    input  instr_t                instr_i,
    output imem_addr_t            fetch_addr_o,
    output reg_addr_t             rs1_addr_o,
    output reg_addr_t             rs2_addr_o,
    input  word_t                 rs1_data_i,
    input  word_t                 rs2_data_i,
    output word_t                 operand_a_o,
    output word_t                 operand_b_o,
    output alu_op_t               alu_op_o,
    input  word_t                 result_i,
    output logic                  wr_en_o,
    output reg_addr_t             wr_addr_o,
    output word_t                 wr_data_o,
    output logic                  done_o
);

    logic [`IMEM_ADDR_W:0]   pc_q;
    logic [`IMEM_ADDR_W+1:0] pc_inc;     // wide enough for count of 16
    logic                    active;     // executing this cycle
    logic                    supported;
    logic                    is_imm;
    logic                    done_q;
    opcode_t                 opcode;
    logic [2:0]              funct3;
    logic [6:0]              funct7;
    word_t                   imm_sext;

    assign opcode   = opcode_t'(instr_i[6:0]);
    assign funct3   = instr_i[14:12];
    assign funct7   = instr_i[31:25];
    assign imm_sext = {{(`XLEN-12){instr_i[31]}}, instr_i[31:20]};

    assign active = run_i && (pc_q < instr_count_i);
    assign pc_inc = pc_q + 1'b1;

    always_comb begin
        alu_op_o  = ALU_ADD;
        supported = 1'b0;
        is_imm    = 1'b0;
        case (opcode)
            OP: begin
                supported = 1'b1;
                case ({funct7, funct3})
                    {F7_BASE, F3_ADD_SUB}: alu_op_o = ALU_ADD;
                    {F7_ALT,  F3_ADD_SUB}: alu_op_o = ALU_SUB;
                    {F7_BASE, F3_AND}:     alu_op_o = ALU_AND;
                    {F7_BASE, F3_OR}:      alu_op_o = ALU_OR;
                    {F7_BASE, F3_XOR}:     alu_op_o = ALU_XOR;
                    {F7_BASE, F3_SLL}:     alu_op_o = ALU_SLL;
                    {F7_BASE, F3_SLT}:     alu_op_o = ALU_SLT;
                    default:               supported = 1'b0;
                endcase
            end
            OP_IMM: begin
                supported = 1'b1;
                is_imm    = 1'b1;
                case (funct3)
                    F3_ADD_SUB: alu_op_o = ALU_ADD;  // addi
                    F3_AND:     alu_op_o = ALU_AND;
                    F3_OR:      alu_op_o = ALU_OR;
                    default:    supported = 1'b0;
                endcase
            end
            default: supported = 1'b0;  // no-op, pc still advances
        endcase
    end

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            pc_q   <= '0;
            done_q <= 1'b0;
        end else begin
            if (active) begin
                pc_q <= pc_inc[`IMEM_ADDR_W:0];
            end
            // set with the last write, sticky until reset
            if (run_i && (pc_inc >= instr_count_i)) begin
                done_q <= 1'b1;
            end
        end
    end

    assign fetch_addr_o = pc_q[`IMEM_ADDR_W-1:0];
    assign rs1_addr_o   = instr_i[19:15];
    assign rs2_addr_o   = instr_i[24:20];
    assign operand_a_o  = rs1_data_i;
    assign operand_b_o  = is_imm ? imm_sext : rs2_data_i;
    assign wr_addr_o    = instr_i[11:7];
    assign wr_en_o      = active && supported && (wr_addr_o != '0);
    assign wr_data_o    = result_i;
    assign done_o       = done_q;

endmodule

`default_nettype wire

// File: hdl/instr_store.sv
`default_nettype none

`include "cpu_lite_defs.svh"

module instr_store
    import isa_pkg::*;
    import host_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  reset,
    input  logic                  host_valid_i,
    input  byte_t                 host_byte_i,
    input  imem_addr_t            fetch_addr_i,
    output instr_t                fetch_instr_o,
    output logic [`IMEM_ADDR_W:0] instr_count_o,
    output logic                  run_o
);

    instr_t                mem [`IMEM_DEPTH];
    load_state_t           state_q;
    logic [1:0]            phase_q;    // lane of next byte
    logic [`IMEM_ADDR_W:0] count_q;    // words stored
    logic [23:0]           asm_q;      // lower three bytes so far
    logic                  end_seen;
    logic                  data_stb;
    logic                  word_done;
    logic                  has_room;

    // 0xFF only ends the program on a word boundary
    assign end_seen  = host_valid_i && (state_q == LOADING) &&
                       (phase_q == 2'd0) && (host_byte_i == `END_MARKER);
    assign data_stb  = host_valid_i && (state_q == LOADING) && !end_seen;
    assign word_done = data_stb && (phase_q == 2'd3);
    assign has_room  = (count_q < `IMEM_DEPTH);  // extra words dropped

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            state_q <= IDLE;
            phase_q <= '0;
            count_q <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (host_valid_i && (host_byte_i == `START_MARKER)) begin
                        state_q <= LOADING;
                        phase_q <= '0;
                        count_q <= '0;
                    end
                end
                LOADING: begin
                    if (end_seen) begin
                        state_q <= RUN;
                    end else if (data_stb) begin
                        phase_q <= phase_q + 2'd1;  // wraps after lane 3
                        if (word_done && has_room) begin
                            count_q <= count_q + 1'b1;
                        end
                    end
                end
                default: state_q <= state_q;  // strobes ignored
            endcase
        end
    end

    // lsb first, so each byte shifts in from the top
    always_ff @(posedge clk_i) begin
        if (data_stb) begin
            asm_q <= {host_byte_i, asm_q[23:8]};
        end
        if (word_done && has_room) begin
            mem[count_q[`IMEM_ADDR_W-1:0]] <= {host_byte_i, asm_q};
        end
    end

    assign fetch_instr_o = mem[fetch_addr_i];
    assign instr_count_o = count_q;
    assign run_o         = (state_q == RUN);

endmodule

`default_nettype wire

// File: hdl/host_pkg.sv
`default_nettype none

`include "cpu_lite_defs.svh"

package host_pkg;

    typedef logic [7:0]              byte_t;
    typedef logic [1:0]              byte_sel_t;   // 0 is bits 7..0
    typedef logic [`IMEM_ADDR_W-1:0] imem_addr_t;

    typedef enum logic [1:0] {
        IDLE,     // waiting for start marker
        LOADING,  // collecting instruction bytes
        RUN       // held until reset
    } load_state_t;

endpackage

`default_nettype wire

// File: hdl/isa_pkg.sv
`default_nettype none

`include "cpu_lite_defs.svh"

package isa_pkg;

    typedef logic [`XLEN-1:0]       word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [31:0]            instr_t;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,  // register-register
        OP_IMM = 7'b0010011   // register-immediate
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SLT
    } alu_op_t;

    // funct3 field values
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct7 field values
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_ALT     = 7'b0100000;  // sub

endpackage

`default_nettype wire

// File: hdl/cpu_lite_defs.svh
`ifndef CPU_LITE_DEFS_SVH
`define CPU_LITE_DEFS_SVH

// datapath
`define XLEN          32
`define REG_COUNT     32
`define REG_ADDR_W    5

// instruction store
`define IMEM_DEPTH    16
`define IMEM_ADDR_W   4

// host loader framing bytes
`define START_MARKER  8'hFE
`define END_MARKER    8'hFF

`endif
